// ==== soc_pkg.sv ====
//////////////////////////////
// SoC fabric package
// Bus widths, AXI4-Lite response codes
// and the fixed memory map
//////////////////////////////

package soc_pkg;

  // Bus types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } axi_resp_e;

  localparam int unsigned WordBytes = 4;

  //////////////////////////////
  // Memory map
  //////////////////////////////

  localparam addr_t DramBase      = 32'h8000_0000;
  localparam addr_t CtrlBase      = 32'hD000_0000;
  localparam addr_t CtrlLength    = 32'h0000_1000;
  localparam addr_t ExitOffset    = 32'h0000_0000;
  localparam addr_t ScratchOffset = 32'h0000_0004;

  // Merge the strobed bytes of a new word into an old one
  function automatic data_t apply_strb(input data_t old_word, input data_t new_word,
                                       input strb_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < WordBytes; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

endpackage

// ==== soc_addr_decoder.sv ====
//////////////////////////////
// Address decoder
// Accepts one AXI4-Lite request at a time, writes first,
// and issues a single request pulse to the selected target
//////////////////////////////

`timescale 1ns/1ps

module soc_addr_decoder #(
  parameter int unsigned NrBanks   = 4,
  parameter int unsigned BankWords = 64
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 aw_valid_i,
  input  soc_pkg::addr_t       aw_addr_i,
  input  logic                 w_valid_i,
  input  soc_pkg::data_t       w_data_i,
  input  soc_pkg::strb_t       w_strb_i,
  input  logic                 ar_valid_i,
  input  soc_pkg::addr_t       ar_addr_i,
  input  logic                 busy_i,
  output logic                 aw_ready_o,
  output logic                 w_ready_o,
  output logic                 ar_ready_o,
  output logic [NrBanks-1:0]   bank_req_o,
  output logic                 ctrl_req_o,
  output logic                 err_req_o,
  output logic                 req_we_o,
  output soc_pkg::addr_t       req_addr_o,
  output soc_pkg::data_t       req_wdata_o,
  output soc_pkg::strb_t       req_strb_o
);
  import soc_pkg::*;

  localparam addr_t       DramLength = addr_t'(NrBanks * BankWords * WordBytes);
  localparam int unsigned ByteBits   = $clog2(WordBytes);

  logic               write_pending;
  logic               can_accept;
  logic               write_hs;
  logic               read_hs;
  logic               accept;
  logic               req_full;
  logic               in_dram;
  logic               in_ctrl;
  addr_t              addr_sel;
  addr_t              word_idx;
  addr_t              bank_idx;
  addr_t              row;
  addr_t              ctrl_offset;
  logic [NrBanks-1:0] bank_sel;
  logic [NrBanks-1:0] bank_req_q;
  logic               ctrl_req_q;
  logic               err_req_q;
  logic               req_we_q;
  addr_t              req_addr_q;
  data_t              req_wdata_q;
  strb_t              req_strb_q;

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign req_full      = (|bank_req_q) | ctrl_req_q | err_req_q;
  assign can_accept    = ~req_full & ~busy_i;
  assign write_pending = aw_valid_i & w_valid_i;

  assign aw_ready_o = write_pending & can_accept;
  assign w_ready_o  = write_pending & can_accept;
  // Reads only go when no full write is waiting
  assign ar_ready_o = ar_valid_i & ~write_pending & can_accept;

  assign write_hs = aw_ready_o;
  assign read_hs  = ar_ready_o;
  assign accept   = write_hs | read_hs;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  assign addr_sel    = write_pending ? aw_addr_i : ar_addr_i;
  assign in_dram     = (addr_sel >= DramBase) && (addr_sel < DramBase + DramLength);
  assign in_ctrl     = (addr_sel >= CtrlBase) && (addr_sel < CtrlBase + CtrlLength);
  assign word_idx    = (addr_sel - DramBase) >> ByteBits;
  assign bank_idx    = word_idx / addr_t'(BankWords);
  assign row         = word_idx % addr_t'(BankWords);
  assign ctrl_offset = addr_sel - CtrlBase;

  always_comb begin
    for (int k = 0; k < NrBanks; k++) begin
      bank_sel[k] = in_dram && (bank_idx == addr_t'(k));
    end
  end

  // Request pulses last exactly one cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bank_req_q <= '0;
      ctrl_req_q <= 1'b0;
      err_req_q  <= 1'b0;
    end else begin
      bank_req_q <= accept ? bank_sel : '0;
      ctrl_req_q <= accept & in_ctrl;
      err_req_q  <= accept & ~in_dram & ~in_ctrl;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_we_q    <= write_hs;
      req_addr_q  <= in_dram ? row : ctrl_offset;
      req_wdata_q <= w_data_i;
      req_strb_q  <= write_hs ? w_strb_i : '0;
    end
  end

  assign bank_req_o  = bank_req_q;
  assign ctrl_req_o  = ctrl_req_q;
  assign err_req_o   = err_req_q;
  assign req_we_o    = req_we_q;
  assign req_addr_o  = req_addr_q;
  assign req_wdata_o = req_wdata_q;
  assign req_strb_o  = req_strb_q;

endmodule

// ==== soc_mem_bank.sv ====
//////////////////////////////
// Main-memory bank
// Word array with byte strobes, one cycle of latency
//////////////////////////////

`timescale 1ns/1ps

module soc_mem_bank #(
  parameter int unsigned BankWords = 64
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t strb_i,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o
);
  import soc_pkg::*;

  localparam int unsigned RowBits = $clog2(BankWords);

  data_t              mem_q [BankWords];
  data_t              rdata_q;
  logic               rvalid_q;
  logic [RowBits-1:0] row;

  assign row = addr_i[RowBits-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[row] <= apply_strb(mem_q[row], wdata_i, strb_i);
      end
      rdata_q <= mem_q[row];
    end
  end

  // Writes are acknowledged like reads
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// ==== soc_ctrl_regs.sv ====
//////////////////////////////
// Control registers
// Exit and scratch registers, one cycle of latency
//////////////////////////////

`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  soc_pkg::addr_t addr_i,
  input  soc_pkg::data_t wdata_i,
  input  soc_pkg::strb_t strb_i,
  output logic           rvalid_o,
  output soc_pkg::data_t rdata_o,
  output logic           slverr_o,
  output soc_pkg::data_t exit_o
);
  import soc_pkg::*;

  logic  hit_exit;
  logic  hit_scratch;
  logic  rvalid_q;
  logic  slverr_q;
  data_t exit_q;
  data_t scratch_q;
  data_t rdata_q;

  assign hit_exit    = (addr_i == ExitOffset);
  assign hit_scratch = (addr_i == ScratchOffset);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q  <= 1'b0;
      slverr_q  <= 1'b0;
      exit_q    <= '0;
      scratch_q <= '0;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        // Unknown offsets leave both registers alone
        slverr_q <= ~(hit_exit | hit_scratch);
        if (we_i && hit_exit) begin
          exit_q <= apply_strb(exit_q, wdata_i, strb_i);
        end
        if (we_i && hit_scratch) begin
          scratch_q <= apply_strb(scratch_q, wdata_i, strb_i);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= hit_exit ? exit_q : (hit_scratch ? scratch_q : '0);
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign slverr_o = slverr_q;
  assign exit_o   = exit_q;

endmodule

// ==== soc_resp_collector.sv ====
//////////////////////////////
// Response collector
// Waits for the addressed target and holds the
// B or R response until the manager takes it
//////////////////////////////

`timescale 1ns/1ps

module soc_resp_collector #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             req_we_i,
  input  logic [NrBanks-1:0]               bank_req_i,
  input  logic                             ctrl_req_i,
  input  logic                             err_req_i,
  input  logic [NrBanks-1:0]               bank_rvalid_i,
  input  soc_pkg::data_t [NrBanks-1:0]     bank_rdata_i,
  input  logic                             ctrl_rvalid_i,
  input  soc_pkg::data_t                   ctrl_rdata_i,
  input  logic                             ctrl_slverr_i,
  input  logic                             b_ready_i,
  input  logic                             r_ready_i,
  output logic                             busy_o,
  output logic                             b_valid_o,
  output soc_pkg::axi_resp_e               b_resp_o,
  output logic                             r_valid_o,
  output soc_pkg::data_t                   r_data_o,
  output soc_pkg::axi_resp_e               r_resp_o
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } collector_state_e;

  collector_state_e state_q, state_d;
  logic             any_req;
  logic             target_valid;
  logic             load;
  logic             resp_taken;
  logic             is_write_q;
  data_t            data_d, data_q;
  axi_resp_e        resp_d, resp_q;

  assign any_req      = (|bank_req_i) | ctrl_req_i | err_req_i;
  assign target_valid = (|bank_rvalid_i) | ctrl_rvalid_i;

  // Pick the answering target, zero data on any error
  always_comb begin
    data_d = '0;
    resp_d = RESP_OKAY;
    for (int k = 0; k < NrBanks; k++) begin
      if (bank_rvalid_i[k]) begin
        data_d = bank_rdata_i[k];
      end
    end
    if (ctrl_rvalid_i) begin
      if (ctrl_slverr_i) begin
        resp_d = RESP_SLVERR;
      end else begin
        data_d = ctrl_rdata_i;
      end
    end
    if (err_req_i) begin
      resp_d = RESP_DECERR;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    load    = 1'b0;
    case (state_q)
      IDLE: begin
        if (err_req_i) begin
          state_d = RESP;
          load    = 1'b1;
        end else if (any_req) begin
          state_d = WAIT;
        end
      end
      WAIT: begin
        if (target_valid) begin
          state_d = RESP;
          load    = 1'b1;
        end
      end
      RESP: begin
        if (resp_taken) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      is_write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && any_req) begin
        is_write_q <= req_we_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_d;
      resp_q <= resp_d;
    end
  end

  assign b_valid_o  = (state_q == RESP) & is_write_q;
  assign r_valid_o  = (state_q == RESP) & ~is_write_q;
  assign resp_taken = (b_valid_o & b_ready_i) | (r_valid_o & r_ready_i);
  assign busy_o     = any_req | (state_q != IDLE);
  assign b_resp_o   = resp_q;
  assign r_resp_o   = resp_q;
  assign r_data_o   = data_q;

endmodule

// ==== soc_top.sv ====
//////////////////////////////
// SoC fabric top level
// AXI4-Lite port onto banked main memory
// and the control registers
//////////////////////////////

`timescale 1ns/1ps

module soc_top #(
  parameter int unsigned NrBanks   = 4,
  parameter int unsigned BankWords = 64
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               aw_valid_i,
  output logic               aw_ready_o,
  input  soc_pkg::addr_t     aw_addr_i,
  input  logic               w_valid_i,
  output logic               w_ready_o,
  input  soc_pkg::data_t     w_data_i,
  input  soc_pkg::strb_t     w_strb_i,
  output logic               b_valid_o,
  input  logic               b_ready_i,
  output soc_pkg::axi_resp_e b_resp_o,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  soc_pkg::addr_t     ar_addr_i,
  output logic               r_valid_o,
  input  logic               r_ready_i,
  output soc_pkg::data_t     r_data_o,
  output soc_pkg::axi_resp_e r_resp_o,
  output soc_pkg::data_t     exit_o
);
  import soc_pkg::*;

  logic [NrBanks-1:0]  bank_req;
  logic                ctrl_req;
  logic                err_req;
  logic                req_we;
  addr_t               req_addr;
  data_t               req_wdata;
  strb_t               req_strb;
  logic                busy;
  logic [NrBanks-1:0]  bank_rvalid;
  data_t [NrBanks-1:0] bank_rdata;
  logic                ctrl_rvalid;
  data_t               ctrl_rdata;
  logic                ctrl_slverr;

  soc_addr_decoder #(
    .NrBanks  (NrBanks  ),
    .BankWords(BankWords)
  ) i_addr_decoder (
    .clk_i      (clk_i     ),
    .rst_n_i    (rst_n_i   ),
    .aw_valid_i (aw_valid_i),
    .aw_addr_i  (aw_addr_i ),
    .w_valid_i  (w_valid_i ),
    .w_data_i   (w_data_i  ),
    .w_strb_i   (w_strb_i  ),
    .ar_valid_i (ar_valid_i),
    .ar_addr_i  (ar_addr_i ),
    .busy_i     (busy      ),
    .aw_ready_o (aw_ready_o),
    .w_ready_o  (w_ready_o ),
    .ar_ready_o (ar_ready_o),
    .bank_req_o (bank_req  ),
    .ctrl_req_o (ctrl_req  ),
    .err_req_o  (err_req   ),
    .req_we_o   (req_we    ),
    .req_addr_o (req_addr  ),
    .req_wdata_o(req_wdata ),
    .req_strb_o (req_strb  )
  );

  //////////////////////////////
  // Main memory
  //////////////////////////////

  for (genvar k = 0; k < NrBanks; k++) begin : gen_banks
    soc_mem_bank #(
      .BankWords(BankWords)
    ) i_mem_bank (
      .clk_i   (clk_i         ),
      .rst_n_i (rst_n_i       ),
      .req_i   (bank_req[k]   ),
      .we_i    (req_we        ),
      .addr_i  (req_addr      ),
      .wdata_i (req_wdata     ),
      .strb_i  (req_strb      ),
      .rvalid_o(bank_rvalid[k]),
      .rdata_o (bank_rdata[k] )
    );
  end

  soc_ctrl_regs i_ctrl_regs (
    .clk_i   (clk_i      ),
    .rst_n_i (rst_n_i    ),
    .req_i   (ctrl_req   ),
    .we_i    (req_we     ),
    .addr_i  (req_addr   ),
    .wdata_i (req_wdata  ),
    .strb_i  (req_strb   ),
    .rvalid_o(ctrl_rvalid),
    .rdata_o (ctrl_rdata ),
    .slverr_o(ctrl_slverr),
    .exit_o  (exit_o     )
  );

  soc_resp_collector #(
    .NrBanks(NrBanks)
  ) i_resp_collector (
    .clk_i        (clk_i      ),
    .rst_n_i      (rst_n_i    ),
    .req_we_i     (req_we     ),
    .bank_req_i   (bank_req   ),
    .ctrl_req_i   (ctrl_req   ),
    .err_req_i    (err_req    ),
    .bank_rvalid_i(bank_rvalid),
    .bank_rdata_i (bank_rdata ),
    .ctrl_rvalid_i(ctrl_rvalid),
    .ctrl_rdata_i (ctrl_rdata ),
    .ctrl_slverr_i(ctrl_slverr),
    .b_ready_i    (b_ready_i  ),
    .r_ready_i    (r_ready_i  ),
    .busy_o       (busy       ),
    .b_valid_o    (b_valid_o  ),
    .b_resp_o     (b_resp_o   ),
    .r_valid_o    (r_valid_o  ),
    .r_data_o     (r_data_o   ),
    .r_resp_o     (r_resp_o   )
  );

endmodule

// ==== tb_clk_gen.sv ====
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== tb_soc_top.sv ====
//////////////////////////////
// SoC fabric testbench
// Random AXI4-Lite traffic checked against a model
// of main memory and the control registers
//////////////////////////////

`timescale 1ns/1ps

module tb_soc_top;
  import soc_pkg::*;

  localparam int unsigned NrBanks   = 4;
  localparam int unsigned BankWords = 64;
  localparam int unsigned DramWords = NrBanks * BankWords;
  localparam int unsigned NumRandom = 300;
  localparam int unsigned NumCtrl   = 40;
  localparam int unsigned NumUnmap  = 40;
  localparam int unsigned NumPrio   = 20;
  localparam int unsigned NumTxn    = DramWords + NumRandom + NumCtrl + NumUnmap + 3 * NumPrio;
  localparam int unsigned PeriodNs  = 100;

  logic       clk;
  logic       rst_n;
  logic       aw_valid;
  logic       aw_ready;
  addr_t      aw_addr;
  logic       w_valid;
  logic       w_ready;
  data_t      w_data;
  strb_t      w_strb;
  logic       b_valid;
  logic       b_ready;
  logic [1:0] b_resp;
  logic       ar_valid;
  logic       ar_ready;
  addr_t      ar_addr;
  logic       r_valid;
  logic       r_ready;
  data_t      r_data;
  logic [1:0] r_resp;
  data_t      exit_o;

  // Reference model state
  data_t       model_mem [DramWords];
  data_t       model_exit;
  data_t       model_scratch;
  integer      seed;
  int unsigned errors;
  int unsigned checks;

  tb_clk_gen #(
    .PeriodNs   (PeriodNs),
    .ResetCycles(8       )
  ) i_clk_gen (
    .clk_o  (clk  ),
    .rst_n_o(rst_n)
  );

  soc_top i_dut (
    .clk_i     (clk     ),
    .rst_n_i   (rst_n   ),
    .aw_valid_i(aw_valid),
    .aw_ready_o(aw_ready),
    .aw_addr_i (aw_addr ),
    .w_valid_i (w_valid ),
    .w_ready_o (w_ready ),
    .w_data_i  (w_data  ),
    .w_strb_i  (w_strb  ),
    .b_valid_o (b_valid ),
    .b_ready_i (b_ready ),
    .b_resp_o  (b_resp  ),
    .ar_valid_i(ar_valid),
    .ar_ready_o(ar_ready),
    .ar_addr_i (ar_addr ),
    .r_valid_o (r_valid ),
    .r_ready_i (r_ready ),
    .r_data_o  (r_data  ),
    .r_resp_o  (r_resp  ),
    .exit_o    (exit_o  )
  );

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic in_dram(addr_t addr);
    return (addr >= DramBase) && (addr < DramBase + DramWords * 4);
  endfunction

  function automatic logic in_ctrl(addr_t addr);
    return (addr >= CtrlBase) && (addr < CtrlBase + CtrlLength);
  endfunction

  // Initial DRAM contents built from every address bit
  function automatic data_t fill_word(addr_t addr);
    return addr ^ {addr[7:0], addr[15:8], addr[23:16], addr[31:24]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic model_access(input logic we, input addr_t addr, input data_t wdata,
                              input strb_t strb, output data_t rdata, output logic [1:0] resp);
    addr_t       off;
    int unsigned idx;
    rdata = '0;
    resp  = RESP_OKAY;
    if (in_dram(addr)) begin
      idx = (addr - DramBase) >> 2;
      if (we) begin
        model_mem[idx] = merge_bytes(model_mem[idx], wdata, strb);
      end else begin
        rdata = model_mem[idx];
      end
    end else if (in_ctrl(addr)) begin
      off = addr - CtrlBase;
      if (off == ExitOffset) begin
        if (we) begin
          model_exit = merge_bytes(model_exit, wdata, strb);
        end else begin
          rdata = model_exit;
        end
      end else if (off == ScratchOffset) begin
        if (we) begin
          model_scratch = merge_bytes(model_scratch, wdata, strb);
        end else begin
          rdata = model_scratch;
        end
      end else begin
        resp = RESP_SLVERR;
      end
    end else begin
      resp = RESP_DECERR;
    end
  endtask

  task automatic drive_write(input addr_t addr, input data_t wdata, input strb_t strb);
    aw_valid <= 1'b1;
    aw_addr  <= addr;
    w_valid  <= 1'b1;
    w_data   <= wdata;
    w_strb   <= strb;
  endtask

  task automatic drive_read(input addr_t addr);
    ar_valid <= 1'b1;
    ar_addr  <= addr;
  endtask

  // Sample ready at the falling edge and drop valid after the accepting edge
  task automatic wait_accept(input logic is_write);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (is_write) begin
        if (aw_ready !== w_ready) begin
          errors++;
          $display("AW and W ready did not rise together at %0t", $time);
        end
        if (ar_ready) begin
          errors++;
          $display("read accepted ahead of a pending write at %0t", $time);
        end
        done = aw_ready & w_ready;
      end else begin
        done = ar_ready;
      end
      @(posedge clk);
    end
    if (is_write) begin
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      ar_valid <= 1'b0;
    end
  endtask

  task automatic wait_resp(input logic is_write, input int unsigned exp_lat,
                           output logic [1:0] resp, output data_t data);
    int unsigned hold;
    int unsigned cycles;
    logic        seen;
    logic        done;
    logic        valid;
    logic        ready;
    logic [1:0]  cur_resp;
    logic [1:0]  held_resp;
    data_t       held_data;
    hold   = rand_word() % 9;
    cycles = 0;
    seen   = 1'b0;
    done   = 1'b0;
    resp   = '0;
    data   = '0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (aw_ready | w_ready | ar_ready) begin
        errors++;
        $display("request accepted while a response was pending at %0t", $time);
      end
      valid    = is_write ? b_valid : r_valid;
      ready    = is_write ? b_ready : r_ready;
      cur_resp = is_write ? b_resp : r_resp;
      if (is_write) begin
        check_val("r_valid_o", r_valid, 1'b0);
      end else begin
        check_val("b_valid_o", b_valid, 1'b0);
      end
      if (valid && !seen) begin
        seen      = 1'b1;
        held_resp = cur_resp;
        held_data = r_data;
        check_val(is_write ? "b_valid_o latency" : "r_valid_o latency", cycles, exp_lat);
      end else if (valid) begin
        // Payload must hold while stalled
        check_val(is_write ? "b_resp_o" : "r_resp_o", cur_resp, held_resp);
        if (!is_write) begin
          check_val("r_data_o", r_data, held_data);
        end
      end
      if (valid && ready) begin
        resp = cur_resp;
        data = r_data;
        done = 1'b1;
      end
      @(posedge clk);
      if (done || cycles < hold) begin
        b_ready <= 1'b0;
        r_ready <= 1'b0;
      end else if (is_write) begin
        b_ready <= 1'b1;
      end else begin
        r_ready <= 1'b1;
      end
    end
  endtask

  task automatic finish_txn(input logic we, input logic [1:0] exp_resp, input data_t exp_data);
    logic [1:0] got_resp;
    data_t      got_data;
    wait_resp(we, (exp_resp == RESP_DECERR) ? 2 : 3, got_resp, got_data);
    if (we) begin
      check_val("b_resp_o", got_resp, exp_resp);
    end else begin
      check_val("r_resp_o", got_resp, exp_resp);
      check_val("r_data_o", got_data, exp_data);
    end
    check_val("exit_o", exit_o, model_exit);
  endtask

  task automatic run_txn(input logic we, input addr_t addr, input data_t wdata, input strb_t strb);
    data_t      exp_data;
    logic [1:0] exp_resp;
    model_access(we, addr, wdata, strb, exp_data, exp_resp);
    if (we) begin
      drive_write(addr, wdata, strb);
    end else begin
      drive_read(addr);
    end
    wait_accept(we);
    finish_txn(we, exp_resp, exp_data);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] r;
    addr_t       addr;
    data_t       wdata;
    data_t       exp_data;
    logic [1:0]  exp_resp;
    seed          = 32'hf67a_f8fa;
    errors        = 0;
    checks        = 0;
    model_exit    = '0;
    model_scratch = '0;
    aw_valid      = 1'b0;
    aw_addr       = '0;
    w_valid       = 1'b0;
    w_data        = '0;
    w_strb        = '0;
    b_ready       = 1'b0;
    ar_valid      = 1'b0;
    ar_addr       = '0;
    r_ready       = 1'b0;

    @(posedge rst_n);
    @(negedge clk);
    check_val("aw_ready_o", aw_ready, 1'b0);
    check_val("w_ready_o", w_ready, 1'b0);
    check_val("ar_ready_o", ar_ready, 1'b0);
    check_val("b_valid_o", b_valid, 1'b0);
    check_val("r_valid_o", r_valid, 1'b0);
    check_val("exit_o", exit_o, '0);
    @(posedge clk);

    // Fill every DRAM word so later reads are defined
    for (int w = 0; w < DramWords; w++) begin
      addr = DramBase + w * 4;
      run_txn(1'b1, addr, fill_word(addr), 4'hf);
    end

    for (int i = 0; i < NumRandom; i++) begin
      r    = rand_word();
      addr = DramBase + (rand_word() % DramWords) * 4;
      run_txn(r[0], addr, rand_word(), r[4:1]);
    end

    for (int i = 0; i < NumCtrl; i++) begin
      r = rand_word();
      case (r[2:1])
        2'd0:    addr = CtrlBase + ExitOffset;
        2'd1:    addr = CtrlBase + ScratchOffset;
        default: addr = CtrlBase + (rand_word() & 32'hfff);
      endcase
      run_txn(r[0], addr, rand_word(), r[6:3]);
    end

    // Unmapped space with the window edges first
    for (int i = 0; i < NumUnmap; i++) begin
      r = rand_word();
      if (i == 0) begin
        addr = DramBase + DramWords * 4;
      end else if (i == 1) begin
        addr = CtrlBase + CtrlLength;
      end else if (i == 2) begin
        addr = DramBase - 4;
      end else begin
        addr = rand_word();
        while (in_dram(addr) || in_ctrl(addr)) begin
          addr = rand_word();
        end
      end
      run_txn(r[0], addr, rand_word(), r[4:1]);
    end

    // AW, W and AR raised together on one address
    for (int i = 0; i < NumPrio; i++) begin
      r     = rand_word();
      addr  = DramBase + (rand_word() % DramWords) * 4;
      wdata = rand_word();
      model_access(1'b1, addr, wdata, r[3:0], exp_data, exp_resp);
      drive_write(addr, wdata, r[3:0]);
      drive_read(addr);
      wait_accept(1'b1);
      finish_txn(1'b1, exp_resp, exp_data);
      model_access(1'b0, addr, '0, '0, exp_data, exp_resp);
      wait_accept(1'b0);
      // Next write waits behind the stalled read response
      wdata = rand_word();
      drive_write(addr, wdata, r[7:4]);
      finish_txn(1'b0, exp_resp, exp_data);
      model_access(1'b1, addr, wdata, r[7:4], exp_data, exp_resp);
      wait_accept(1'b1);
      finish_txn(1'b1, exp_resp, exp_data);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog allowing 20 cycles per transaction
  initial begin
    #((NumTxn * 20 + 20) * PeriodNs);
    $display("timeout: the transactions did not complete in time (errors so far: %0d)", errors);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
soc_pkg.sv
soc_addr_decoder.sv
soc_mem_bank.sv
soc_ctrl_regs.sv
soc_resp_collector.sv
soc_top.sv
tb_clk_gen.sv
tb_soc_top.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  # Package first, then the RTL blocks and the top level
  - soc_pkg.sv
  - soc_addr_decoder.sv
  - soc_mem_bank.sv
  - soc_ctrl_regs.sv
  - soc_resp_collector.sv
  - soc_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_soc_top.sv
